// ==== logic/spi_pkg.sv ====
// Shared request, response and byte types plus FSM state enums for the SPI bridge

package spi_pkg;

    // ==============================
    // Host side types
    // ==============================

    // Register operation
    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } spi_op_e;

    // Register access request from the host
    typedef struct packed {
        spi_op_e    op;
        logic [6:0] addr;
        logic [7:0] wdata;
    } reg_request_t;

    // Response back to the host, rdata is the value before the access
    typedef struct packed {
        spi_op_e    op;
        logic [6:0] addr;
        logic [7:0] rdata;
    } reg_response_t;

    // ==============================
    // Byte engine types
    // ==============================

    // One byte to shift, last releases select afterwards
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } byte_request_t;

    typedef enum logic [1:0] {
        engine_idle   = 2'd0,
        engine_shift  = 2'd1,
        engine_finish = 2'd2
    } engine_state_e;

    typedef enum logic [1:0] {
        seq_idle    = 2'd0,
        seq_command = 2'd1,
        seq_data    = 2'd2,
        seq_respond = 2'd3
    } sequencer_state_e;

endpackage

// ==== logic/spi_byte_engine.sv ====
// SPI mode 0 byte engine: shifts one byte each way and drives select, clock and data out
`timescale 1ns/10ps

module spi_byte_engine #(
    parameter int sck_half_period = 1
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   byte_start,
    input  spi_pkg::byte_request_t byte_out,
    input  logic                   miso,
    output logic                   byte_done,
    output logic [7:0]             byte_in,
    output logic                   sck,
    output logic                   mosi,
    output logic                   ss
);

    import spi_pkg::*;

    // Counter wide enough for one SPI half-period
    localparam int count_width = (sck_half_period > 1) ? $clog2(sck_half_period) : 1;
    localparam logic [count_width-1:0] half_last = count_width'(sck_half_period - 1);

    engine_state_e          state;
    engine_state_e          state_next;
    logic [count_width-1:0] half_count;
    logic [count_width-1:0] half_count_next;
    logic [2:0]             bit_count;
    logic [2:0]             bit_count_next;
    logic [7:0]             shift_reg;
    logic [7:0]             shift_reg_next;
    logic [7:0]             byte_in_next;
    logic                   last_byte;
    logic                   last_byte_next;
    logic                   byte_done_next;
    logic                   sck_next;
    logic                   mosi_next;
    logic                   ss_next;
    logic                   half_end;

    // End of the current SPI half-period
    assign half_end = (half_count == half_last);

    // ==============================
    // Next state and outputs
    // ==============================
    always_comb begin
        state_next      = state;
        half_count_next = half_count;
        bit_count_next  = bit_count;
        shift_reg_next  = shift_reg;
        byte_in_next    = byte_in;
        last_byte_next  = last_byte;
        byte_done_next  = 1'b0;
        sck_next        = sck;
        mosi_next       = mosi;
        ss_next         = ss;

        case (state)
            engine_idle: begin
                sck_next = 1'b0;
                // Select is left as is so it can span two bytes
                if (byte_start) begin
                    state_next      = engine_shift;
                    half_count_next = '0;
                    bit_count_next  = 3'd0;
                    shift_reg_next  = byte_out.data;
                    last_byte_next  = byte_out.last;
                    mosi_next       = byte_out.data[7];
                    ss_next         = 1'b0;
                end
            end

            engine_shift: begin
                if (half_end) begin
                    half_count_next = '0;
                    sck_next        = ~sck;
                    if (!sck) begin
                        // Rising edge, take in the peripheral bit
                        shift_reg_next = {shift_reg[6:0], miso};
                    end else begin
                        // Falling edge, next bit out
                        bit_count_next = bit_count + 3'd1;
                        if (bit_count == 3'd7) begin
                            mosi_next  = 1'b0;
                            state_next = engine_finish;
                        end else begin
                            mosi_next = shift_reg[7];
                        end
                    end
                end else begin
                    half_count_next = half_count + count_width'(1);
                end
            end

            engine_finish: begin
                byte_in_next   = shift_reg;
                byte_done_next = 1'b1;
                if (last_byte) begin
                    ss_next = 1'b1;
                end
                state_next = engine_idle;
            end

            default: begin
                state_next = engine_idle;
                sck_next   = 1'b0;
                mosi_next  = 1'b0;
                ss_next    = 1'b1;
            end
        endcase
    end

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= engine_idle;
            half_count <= '0;
            bit_count  <= 3'd0;
            byte_done  <= 1'b0;
            sck        <= 1'b0;
            mosi       <= 1'b0;
            ss         <= 1'b1;
        end else begin
            state      <= state_next;
            half_count <= half_count_next;
            bit_count  <= bit_count_next;
            byte_done  <= byte_done_next;
            sck        <= sck_next;
            mosi       <= mosi_next;
            ss         <= ss_next;
        end
    end

    // Data path
    always_ff @(posedge clock) begin
        shift_reg <= shift_reg_next;
        byte_in   <= byte_in_next;
        last_byte <= last_byte_next;
    end

endmodule

// ==== logic/spi_register_sequencer.sv ====
// Register request sequencer: builds the two-byte SPI frame and the host response
`timescale 1ns/10ps

module spi_register_sequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   request_valid,
    input  spi_pkg::reg_request_t  request,
    input  logic                   byte_done,
    input  logic [7:0]             byte_in,
    output logic                   busy,
    output logic                   byte_start,
    output spi_pkg::byte_request_t byte_out,
    output logic                   response_valid,
    output spi_pkg::reg_response_t response
);

    import spi_pkg::*;

    sequencer_state_e state;
    sequencer_state_e state_next;
    reg_request_t     held_request;
    reg_request_t     held_request_next;
    reg_response_t    response_next;
    byte_request_t    byte_out_next;
    logic             busy_next;
    logic             byte_start_next;
    logic             response_valid_next;

    // ==============================
    // Frame sequencing
    // ==============================
    always_comb begin
        state_next          = state;
        held_request_next   = held_request;
        response_next       = response;
        byte_out_next       = byte_out;
        busy_next           = busy;
        byte_start_next     = 1'b0;
        response_valid_next = 1'b0;

        case (state)
            seq_idle: begin
                // Strobes while busy never reach here
                if (request_valid) begin
                    held_request_next = request;
                    // Command byte is the read flag then the address
                    byte_out_next     = '{data: {request.op == op_read, request.addr},
                                          last: 1'b0};
                    byte_start_next   = 1'b1;
                    busy_next         = 1'b1;
                    state_next        = seq_command;
                end
            end

            seq_command: begin
                if (byte_done) begin
                    // Data byte closes the frame
                    if (held_request.op == op_write) begin
                        byte_out_next = '{data: held_request.wdata, last: 1'b1};
                    end else begin
                        byte_out_next = '{data: 8'h00, last: 1'b1};
                    end
                    byte_start_next = 1'b1;
                    state_next      = seq_data;
                end
            end

            seq_data: begin
                if (byte_done) begin
                    // Peripheral returned the old register value
                    response_next = '{op:    held_request.op,
                                      addr:  held_request.addr,
                                      rdata: byte_in};
                    state_next    = seq_respond;
                end
            end

            seq_respond: begin
                response_valid_next = 1'b1;
                busy_next           = 1'b0;
                state_next          = seq_idle;
            end

            default: begin
                busy_next  = 1'b0;
                state_next = seq_idle;
            end
        endcase
    end

    // ==============================
    // Registers
    // ==============================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= seq_idle;
            busy           <= 1'b0;
            byte_start     <= 1'b0;
            response_valid <= 1'b0;
        end else begin
            state          <= state_next;
            busy           <= busy_next;
            byte_start     <= byte_start_next;
            response_valid <= response_valid_next;
        end
    end

    // Captured request and outgoing payloads
    always_ff @(posedge clock) begin
        held_request <= held_request_next;
        byte_out     <= byte_out_next;
        response     <= response_next;
    end

endmodule

// ==== logic/spi_register_bridge.sv ====
// Top level of the SPI register bridge: sequencer plus byte engine
`timescale 1ns/10ps

module spi_register_bridge #(
    parameter int sck_half_period = 1
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   request_valid,
    input  spi_pkg::reg_request_t  request,
    input  logic                   miso,
    output logic                   busy,
    output logic                   response_valid,
    output spi_pkg::reg_response_t response,
    output logic                   sck,
    output logic                   mosi,
    output logic                   ss
);

    import spi_pkg::*;

    // Sequencer to engine byte handshake
    logic          byte_start;
    byte_request_t byte_out;
    logic          byte_done;
    logic [7:0]    byte_in;

    spi_register_sequencer i_sequencer (
        .clock          (clock),
        .reset          (reset),
        .request_valid  (request_valid),
        .request        (request),
        .byte_done      (byte_done),
        .byte_in        (byte_in),
        .busy           (busy),
        .byte_start     (byte_start),
        .byte_out       (byte_out),
        .response_valid (response_valid),
        .response       (response)
    );

    // SPI clock rate is set here
    spi_byte_engine #(
        .sck_half_period (sck_half_period)
    ) i_engine (
        .clock      (clock),
        .reset      (reset),
        .byte_start (byte_start),
        .byte_out   (byte_out),
        .miso       (miso),
        .byte_done  (byte_done),
        .byte_in    (byte_in),
        .sck        (sck),
        .mosi       (mosi),
        .ss         (ss)
    );

endmodule

// ==== verification/spi_peripheral_model.sv ====
// Behavioral SPI mode 0 peripheral with a 128 entry register file and frame length check
`timescale 1ns/10ps

module spi_peripheral_model (
    input  logic sck,
    input  logic mosi,
    input  logic ss,
    output logic miso,
    output logic frame_error,
    output int   frame_count
);

    logic [7:0]  registers [128];
    logic [15:0] frame_bits;
    logic [7:0]  tx_byte;
    int          rise_count;

    initial begin
        // Fill pattern covers every address bit, 37 is odd so all entries differ
        for (int i = 0; i < 128; i++) begin
            registers[i] = 8'(i * 37 + 92);
        end
        miso        = 1'b0;
        frame_error = 1'b0;
        frame_count = 0;
        tx_byte     = 8'h00;
        forever begin
            @(negedge ss);
            rise_count = 0;
            frame_bits = '0;
            miso       = 1'b0;
            while (ss == 1'b0) begin
                @(sck or ss);
                if (ss == 1'b0 && sck == 1'b1) begin
                    // Rising edge, take mosi
                    frame_bits = {frame_bits[14:0], mosi};
                    rise_count = rise_count + 1;
                end else if (ss == 1'b0 && sck == 1'b0) begin
                    // Falling edge, address is complete after 8 rises
                    if (rise_count == 8) begin
                        tx_byte = registers[frame_bits[6:0]];
                        miso    = tx_byte[7];
                    end else if (rise_count > 8 && rise_count < 16) begin
                        tx_byte = {tx_byte[6:0], 1'b0};
                        miso    = tx_byte[7];
                    end
                end
            end
            // Select released, frame must hold both bytes
            if (rise_count != 16) begin
                $display("Peripheral saw %0d sck rises in one frame instead of 16", rise_count);
                frame_error = 1'b1;
            end else begin
                frame_count = frame_count + 1;
                if (frame_bits[15] == 1'b0) begin
                    registers[frame_bits[14:8]] = frame_bits[7:0];
                end
            end
        end
    end

endmodule

// ==== verification/spi_register_bridge_asserts.sv ====
// Concurrent assertions on the SPI wires and the host strobe, bound to the bridge
`timescale 1ns/10ps

module spi_register_bridge_asserts (
    input logic clock,
    input logic reset,
    input logic ss,
    input logic sck,
    input logic mosi,
    input logic request_valid,
    input logic busy,
    input logic response_valid
);

    logic select_failed   = 1'b0;
    logic mosi_failed     = 1'b0;
    logic response_failed = 1'b0;
    logic strobe_failed   = 1'b0;
    logic any_failure;

    assign any_failure = select_failed | mosi_failed | response_failed | strobe_failed;

    // SPI clock idles low outside a frame
    sck_low_when_deselected: assert property (
        @(posedge clock) disable iff (reset) ss |-> !sck
    ) else begin
        $error("sck is high while ss is high");
        select_failed = 1'b1;
    end

    // Mode 0 data only moves while sck is low
    mosi_stable_while_sck_high: assert property (
        @(posedge clock) disable iff (reset) sck |-> $stable(mosi)
    ) else begin
        $error("mosi changed while sck is high");
        mosi_failed = 1'b1;
    end

    response_single_cycle: assert property (
        @(posedge clock) disable iff (reset) response_valid |=> !response_valid
    ) else begin
        $error("response_valid lasted more than one cycle");
        response_failed = 1'b1;
    end

    no_request_while_busy: assert property (
        @(posedge clock) disable iff (reset) busy |-> !request_valid
    ) else begin
        $error("request_valid strobed while busy");
        strobe_failed = 1'b1;
    end

endmodule

bind spi_register_bridge spi_register_bridge_asserts i_asserts (
    .clock          (clock),
    .reset          (reset),
    .ss             (ss),
    .sck            (sck),
    .mosi           (mosi),
    .request_valid  (request_valid),
    .busy           (busy),
    .response_valid (response_valid)
);

// ==== verification/spi_register_bridge_tb.sv ====
// Testbench for the SPI register bridge with stimulus, shadow reference, compare tasks and timeout
`timescale 1ns/10ps

module spi_register_bridge_tb;

    import spi_pkg::*;

    localparam int sck_half_period = 1;
    localparam int random_count    = 60;
    // About 65 transactions of under 50 cycles each plus reset and margin
    localparam int cycle_limit     = 4000;

    logic          clock;
    logic          reset;
    logic          request_valid;
    reg_request_t  request;
    logic          busy;
    logic          response_valid;
    reg_response_t response;
    logic          sck;
    logic          mosi;
    logic          miso;
    logic          ss;
    logic          frame_error;
    int            frame_count;

    // Expected register contents and outstanding responses
    logic [7:0]    shadow [128];
    reg_response_t expected_queue [$];
    reg_response_t last_response;
    logic [31:0]   rng_state;
    int            sent_count     = 0;
    int            response_count = 0;
    int            cycle_count    = 0;

    spi_register_bridge #(
        .sck_half_period (sck_half_period)
    ) i_dut (
        .clock          (clock),
        .reset          (reset),
        .request_valid  (request_valid),
        .request        (request),
        .miso           (miso),
        .busy           (busy),
        .response_valid (response_valid),
        .response       (response),
        .sck            (sck),
        .mosi           (mosi),
        .ss             (ss)
    );

    spi_peripheral_model i_peripheral (
        .sck         (sck),
        .mosi        (mosi),
        .ss          (ss),
        .miso        (miso),
        .frame_error (frame_error),
        .frame_count (frame_count)
    );

    always begin
        clock = 1'b0;
        #50;
        clock = 1'b1;
        #50;
    end

    // ==============================
    // Reference and helpers
    // ==============================
    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Old register value comes back with op and addr echoed
    function automatic reg_response_t expected_response(input reg_request_t req);
        reg_response_t result;
        result.op    = req.op;
        result.addr  = req.addr;
        result.rdata = shadow[req.addr];
        return result;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_response(input string name, input reg_response_t expected,
                                  input reg_response_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected op=%0d addr=%h rdata=%h, %s",
                     $time, name, expected.op, expected.addr, expected.rdata,
                     $sformatf("actual op=%0d addr=%h rdata=%h", actual.op, actual.addr,
                               actual.rdata));
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, actual %b",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic random_request(output reg_request_t req, output logic [1:0] gap);
        rng_state = xorshift(rng_state);
        req.op    = spi_op_e'(rng_state[0]);
        req.addr  = rng_state[7:1];
        req.wdata = rng_state[15:8];
        gap       = rng_state[17:16];
    endtask

    // Strobe one request and wait for its response
    task automatic send_request(input reg_request_t req);
        int target;
        target = response_count + 1;
        expected_queue.push_back(expected_response(req));
        if (req.op == op_write) begin
            shadow[req.addr] = req.wdata;
        end
        sent_count    = sent_count + 1;
        request       = req;
        request_valid = 1'b1;
        @(posedge clock);
        #10;
        request_valid = 1'b0;
        // Busy rises the cycle after the accepted strobe
        @(negedge clock);
        check_bit("busy", 1'b1, busy);
        while (response_count < target) begin
            @(posedge clock);
        end
        #10;
    endtask

    // ==============================
    // Compare, monitors and timeout
    // ==============================
    always @(negedge clock) begin : compare
        reg_response_t expected;
        if (!reset && response_valid) begin
            if (expected_queue.size() == 0) begin
                $display("Response arrived at %0t ns with no request outstanding", $time);
                abort_run();
            end else begin
                expected = expected_queue.pop_front();
                check_response("response", expected, response);
                // Busy drops together with the response strobe
                check_bit("busy", 1'b0, busy);
                last_response  = response;
                response_count = response_count + 1;
            end
        end
    end

    always @(negedge clock) begin
        if (frame_error) begin
            $display("The peripheral model received a malformed SPI frame");
            abort_run();
        end else if (i_dut.i_asserts.any_failure) begin
            $display("A bound protocol assertion failed");
            abort_run();
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Simulation ran for %0d cycles without finishing the tests", cycle_count);
            abort_run();
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin : stimulus
        reg_request_t req;
        logic [1:0]   gap;
        logic [6:0]   addr;
        logic [7:0]   value;
        int           frames_before;
        rng_state     = 32'd79422;
        reset         = 1'b1;
        request_valid = 1'b0;
        request       = '0;
        repeat (3) @(posedge clock);
        #10;
        reset = 1'b0;
        for (int i = 0; i < 128; i++) begin
            shadow[i] = i_peripheral.registers[i];
        end

        // Idle outputs after reset
        @(negedge clock);
        check_bit("ss", 1'b1, ss);
        check_bit("sck", 1'b0, sck);
        check_bit("busy", 1'b0, busy);
        check_bit("response_valid", 1'b0, response_valid);
        @(posedge clock);
        #10;

        // Write, read back, then overwrite
        rng_state = xorshift(rng_state);
        addr      = rng_state[6:0];
        value     = rng_state[15:8];
        send_request(reg_request_t'{op: op_write, addr: addr, wdata: value});
        send_request(reg_request_t'{op: op_read, addr: addr, wdata: 8'h00});
        check_response("read after write", reg_response_t'{op: op_read, addr: addr, rdata: value},
                       last_response);
        send_request(reg_request_t'{op: op_write, addr: addr, wdata: ~value});
        check_response("write previous value",
                       reg_response_t'{op: op_write, addr: addr, rdata: value}, last_response);

        for (int n = 0; n < random_count; n++) begin
            random_request(req, gap);
            repeat (gap) begin
                @(posedge clock);
                #10;
            end
            send_request(req);
        end

        // Second strobe lands the cycle after the first response
        frames_before = frame_count;
        random_request(req, gap);
        send_request(req);
        random_request(req, gap);
        send_request(req);
        if (frame_count != frames_before + 2) begin
            $display("Back to back requests gave %0d frames instead of 2",
                     frame_count - frames_before);
            abort_run();
        end

        @(negedge clock);
        if (response_count == sent_count && expected_queue.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d requests sent but %0d responses received", sent_count, response_count);
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// ==== sim.f ====
logic/spi_pkg.sv
logic/spi_byte_engine.sv
logic/spi_register_sequencer.sv
logic/spi_register_bridge.sv
verification/spi_peripheral_model.sv
verification/spi_register_bridge_asserts.sv
verification/spi_register_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SPI register bridge testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module spi_register_bridge_tb \
    --Mdir obj_dir \
    -f sim.f

# Assertion errors must not end the run before the testbench reports them
output=$(./obj_dir/Vspi_register_bridge_tb +verilator+error+limit+10 2>&1) || true
echo "$output"

if grep -qx "Test passed" <<< "$output"; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
